// ==== design/plotter_settings.svh ====
`ifndef PLOTTER_SETTINGS_SVH
`define PLOTTER_SETTINGS_SVH

// unsigned plot coordinate, 0 to 1023.
`define POS_BITS 10

// signed operation argument.
`define ARG_BITS 12

// step pulse high time, low time is the same.
`define PULSE_CYCLES 2

`endif

// ==== design/plotter_pkg.sv ====
`include "plotter_settings.svh"

package plotter_pkg;

	typedef enum logic [1:0] {
		OP_G00 = 2'd0, // rapid, pen up.
		OP_G01 = 2'd1, // linear, pen down.
		OP_G90 = 2'd2, // absolute mode.
		OP_G91 = 2'd3  // relative mode.
	} op_cmd_t;

	typedef logic [`POS_BITS-1:0] pos_t;

	typedef logic signed [`ARG_BITS-1:0] arg_t;

	// one bit wider than pos_t to hold a full signed span.
	typedef logic signed [`POS_BITS:0] delta_t;

endpackage

// ==== design/gcode_decoder.sv ====
`timescale 1ns/1ps
`include "plotter_settings.svh"

module gcode_decoder import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic op_valid,
	output logic op_ready,
	input op_cmd_t op_cmd,
	input arg_t op_arg_1,
	input arg_t op_arg_2,
	output logic mv_valid,
	input logic mv_ready,
	output delta_t mv_dx,
	output delta_t mv_dy,
	output logic mv_pen
);

	localparam int SUM_BITS = `ARG_BITS + 1;
	localparam pos_t POS_MAX = '1;

	logic abs_mode;
	pos_t pos_x;
	pos_t pos_y;
	pos_t tgt_x;
	pos_t tgt_y;
	logic op_take;

	// target for one axis, clamped to the plot area.
	function automatic pos_t resolve(input logic abs_sel, input pos_t cur, input arg_t arg);
		logic signed [SUM_BITS-1:0] sum;
		if (abs_sel)
			sum = SUM_BITS'(arg);
		else
			sum = $signed({{(SUM_BITS-`POS_BITS){1'b0}}, cur}) + SUM_BITS'(arg);
		if (sum < 0)
			return '0;
		else if (sum > $signed(SUM_BITS'(POS_MAX)))
			return POS_MAX;
		else
			return sum[`POS_BITS-1:0];
	endfunction

	assign op_ready = ~mv_valid; // one move buffered at most.
	assign op_take = op_valid && op_ready;
	assign tgt_x = resolve(abs_mode, pos_x, op_arg_1);
	assign tgt_y = resolve(abs_mode, pos_y, op_arg_2);

	always_ff @(posedge out_x) begin
		if (rst) begin
			abs_mode <= 1'b1;
			pos_x <= '0;
			pos_y <= '0;
			mv_valid <= 1'b0;
		end else begin
			if (mv_valid && mv_ready)
				mv_valid <= 1'b0;
			if (op_take) begin
				case (op_cmd)
				OP_G90: abs_mode <= 1'b1;
				OP_G91: abs_mode <= 1'b0;
				default: begin
					if (tgt_x != pos_x || tgt_y != pos_y) begin // zero moves dropped.
						mv_valid <= 1'b1;
						pos_x <= tgt_x;
						pos_y <= tgt_y;
					end
				end
				endcase
			end
		end
	end

	always_ff @(posedge out_x) begin
		if (op_take) begin
			mv_dx <= $signed({1'b0, tgt_x}) - $signed({1'b0, pos_x});
			mv_dy <= $signed({1'b0, tgt_y}) - $signed({1'b0, pos_y});
			mv_pen <= (op_cmd == OP_G01);
		end
	end

endmodule

// ==== design/line_interpolator.sv ====
`timescale 1ns/1ps
`include "plotter_settings.svh"

module line_interpolator import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic mv_valid,
	output logic mv_ready,
	input delta_t mv_dx,
	input delta_t mv_dy,
	input logic mv_pen,
	output logic ev_valid,
	input logic ev_ready,
	output logic ev_step_x,
	output logic ev_step_y,
	output logic ev_dir_x,
	output logic ev_dir_y,
	output logic ev_pen
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} interp_state_t;

	interp_state_t state;
	pos_t in_adx;
	pos_t in_ady;
	pos_t in_major;
	pos_t in_minor;
	pos_t major;
	pos_t minor;
	pos_t remain;
	logic [`POS_BITS:0] err;
	logic [`POS_BITS:0] err_sum;
	logic [`POS_BITS:0] err_next;
	logic x_major;
	logic minor_step;
	logic mv_take;
	logic ev_take;

	function automatic pos_t abs_delta(input delta_t d);
		delta_t neg;
		neg = -d;
		return d[`POS_BITS] ? neg[`POS_BITS-1:0] : d[`POS_BITS-1:0];
	endfunction

	assign in_adx = abs_delta(mv_dx);
	assign in_ady = abs_delta(mv_dy);
	assign in_major = (in_adx >= in_ady) ? in_adx : in_ady;
	assign in_minor = (in_adx >= in_ady) ? in_ady : in_adx;

	assign mv_ready = (state == ST_IDLE);
	assign mv_take = mv_valid && mv_ready;
	assign ev_valid = (state == ST_RUN);
	assign ev_take = ev_valid && ev_ready;

	// bresenham error step, err stays below major.
	assign err_sum = err + {1'b0, minor};
	assign minor_step = (err_sum >= {1'b0, major});
	assign err_next = minor_step ? err_sum - {1'b0, major} : err_sum;

	assign ev_step_x = x_major | minor_step;
	assign ev_step_y = ~x_major | minor_step;

	always_ff @(posedge out_x) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
			ST_IDLE: begin
				if (mv_take && in_major != '0)
					state <= ST_RUN;
			end
			ST_RUN: begin
				if (ev_take && remain == pos_t'(1)) // last event out.
					state <= ST_IDLE;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge out_x) begin
		if (mv_take) begin
			x_major <= (in_adx >= in_ady); // ties go to x.
			major <= in_major;
			minor <= in_minor;
			remain <= in_major;
			err <= {1'b0, in_major >> 1}; // centred start.
			ev_dir_x <= ~mv_dx[`POS_BITS];
			ev_dir_y <= ~mv_dy[`POS_BITS];
			ev_pen <= mv_pen;
		end else if (ev_take) begin
			remain <= remain - 1'b1;
			err <= err_next;
		end
	end

endmodule

// ==== design/step_pulse_gen.sv ====
`timescale 1ns/1ps
`include "plotter_settings.svh"

module step_pulse_gen (
	input logic out_x,
	input logic rst,
	input logic ev_valid,
	output logic ev_ready,
	input logic ev_step_x,
	input logic ev_step_y,
	input logic ev_dir_x,
	input logic ev_dir_y,
	input logic ev_pen,
	output logic pulse_x,
	output logic dir_x,
	output logic pulse_y,
	output logic dir_y,
	output logic pen_down
);

	localparam int PH_BITS = $clog2(`PULSE_CYCLES + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HIGH,
		ST_LOW
	} pulse_state_t;

	pulse_state_t state;
	logic [PH_BITS-1:0] phase;
	logic phase_end;

	assign ev_ready = (state == ST_IDLE);
	assign phase_end = (phase == PH_BITS'(`PULSE_CYCLES - 1));

	always_ff @(posedge out_x) begin
		if (rst) begin
			state <= ST_IDLE;
			phase <= '0;
			pulse_x <= 1'b0;
			pulse_y <= 1'b0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
			pen_down <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (ev_valid) begin
					dir_x <= ev_dir_x; // held until next event.
					dir_y <= ev_dir_y;
					pen_down <= ev_pen;
					pulse_x <= ev_step_x;
					pulse_y <= ev_step_y;
					phase <= '0;
					state <= ST_HIGH;
				end
			end
			ST_HIGH: begin
				if (phase_end) begin
					pulse_x <= 1'b0;
					pulse_y <= 1'b0;
					phase <= '0;
					state <= ST_LOW;
				end else begin
					phase <= phase + 1'b1;
				end
			end
			ST_LOW: begin
				if (phase_end)
					state <= ST_IDLE; // low time done.
				else
					phase <= phase + 1'b1;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== design/plotter_top.sv ====
`timescale 1ns/1ps

module plotter_top import plotter_pkg::*; (
	input logic out_x,
	input logic rst,
	input logic op_valid,
	output logic op_ready,
	input op_cmd_t op_cmd,
	input arg_t op_arg_1,
	input arg_t op_arg_2,
	output logic pulse_x,
	output logic dir_x,
	output logic pulse_y,
	output logic dir_y,
	output logic pen_down
);

	// decoder to interpolator.
	logic mv_valid;
	logic mv_ready;
	delta_t mv_dx;
	delta_t mv_dy;
	logic mv_pen;

	// interpolator to pulse generator.
	logic ev_valid;
	logic ev_ready;
	logic ev_step_x;
	logic ev_step_y;
	logic ev_dir_x;
	logic ev_dir_y;
	logic ev_pen;

	gcode_decoder u_decoder (
		.out_x(out_x),
		.rst(rst),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.op_cmd(op_cmd),
		.op_arg_1(op_arg_1),
		.op_arg_2(op_arg_2),
		.mv_valid(mv_valid),
		.mv_ready(mv_ready),
		.mv_dx(mv_dx),
		.mv_dy(mv_dy),
		.mv_pen(mv_pen)
	);

	line_interpolator u_interp (
		.out_x(out_x),
		.rst(rst),
		.mv_valid(mv_valid),
		.mv_ready(mv_ready),
		.mv_dx(mv_dx),
		.mv_dy(mv_dy),
		.mv_pen(mv_pen),
		.ev_valid(ev_valid),
		.ev_ready(ev_ready),
		.ev_step_x(ev_step_x),
		.ev_step_y(ev_step_y),
		.ev_dir_x(ev_dir_x),
		.ev_dir_y(ev_dir_y),
		.ev_pen(ev_pen)
	);

	step_pulse_gen u_pulse (
		.out_x(out_x),
		.rst(rst),
		.ev_valid(ev_valid),
		.ev_ready(ev_ready),
		.ev_step_x(ev_step_x),
		.ev_step_y(ev_step_y),
		.ev_dir_x(ev_dir_x),
		.ev_dir_y(ev_dir_y),
		.ev_pen(ev_pen),
		.pulse_x(pulse_x),
		.dir_x(dir_x),
		.pulse_y(pulse_y),
		.dir_y(dir_y),
		.pen_down(pen_down)
	);

endmodule

// ==== tests/plotter_tb.sv ====
`timescale 1ns/1ps
`include "plotter_settings.svh"

module plotter_tb import plotter_pkg::*; ();

	localparam int NUM_OPS = 60;
	localparam int MAX_GAP = 6;
	localparam int POS_MAX = (1 << `POS_BITS) - 1;
	localparam int EVENT_CYCLES = 2 * `PULSE_CYCLES + 2; // high, low, handshake and slack.
	localparam int LIMIT = 16 + 20 + NUM_OPS * (POS_MAX * EVENT_CYCLES + MAX_GAP + 8) + 400;

	logic out_x;
	logic rst;
	logic op_valid;
	logic op_ready;
	op_cmd_t op_cmd;
	arg_t op_arg_1;
	arg_t op_arg_2;
	logic pulse_x;
	logic dir_x;
	logic pulse_y;
	logic dir_y;
	logic pen_down;

	// reference model state.
	bit model_abs = 1'b1;
	int model_x = 0;
	int model_y = 0;
	int exp_dx[$];
	int exp_dy[$];
	bit exp_pen[$];

	// observed pulse state.
	logic prev_x = 1'b0;
	logic prev_y = 1'b0;
	int cnt_x = 0;
	int cnt_y = 0;
	int acc_x = 0;
	int acc_y = 0;
	int cycles = 0;

	plotter_top DUT (
		.out_x(out_x),
		.rst(rst),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.op_cmd(op_cmd),
		.op_arg_1(op_arg_1),
		.op_arg_2(op_arg_2),
		.pulse_x(pulse_x),
		.dir_x(dir_x),
		.pulse_y(pulse_y),
		.dir_y(dir_y),
		.pen_down(pen_down)
	);

	always #20 out_x = ~out_x;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic signed [31:0] expected,
			input logic signed [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("CHECK FAILED: %s expected %0d actual %0d", name, expected, actual));
	endtask

	function automatic int clamp_coord(input int v);
		if (v < 0)
			return 0;
		else if (v > POS_MAX)
			return POS_MAX;
		return v;
	endfunction

	function automatic int magnitude(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic void model_op(input op_cmd_t cmd, input int a1, input int a2);
		int tx;
		int ty;
		if (cmd == OP_G90) begin
			model_abs = 1'b1;
		end else if (cmd == OP_G91) begin
			model_abs = 1'b0;
		end else begin
			tx = clamp_coord(model_abs ? a1 : model_x + a1);
			ty = clamp_coord(model_abs ? a2 : model_y + a2);
			if (tx != model_x || ty != model_y) begin
				exp_dx.push_back(tx - model_x);
				exp_dy.push_back(ty - model_y);
				exp_pen.push_back(cmd == OP_G01);
			end
			model_x = tx;
			model_y = ty;
		end
	endfunction

	function automatic int random_arg();
		if (model_abs)
			return int'($urandom % 1300) - 130; // reaches past both edges.
		return int'($urandom % 801) - 400;
	endfunction

	// called and returns at 2 ns after a rising edge.
	task automatic send_op(input op_cmd_t cmd, input int a1, input int a2);
		logic taken;
		op_valid = 1'b1;
		op_cmd = cmd;
		op_arg_1 = arg_t'(a1);
		op_arg_2 = arg_t'(a2);
		model_op(cmd, a1, a2);
		taken = 1'b0;
		while (!taken) begin
			@(negedge out_x);
			taken = op_ready;
			@(posedge out_x);
			#2;
		end
		op_valid = 1'b0;
	endtask

	task automatic random_op();
		int kind;
		int a1;
		int a2;
		op_cmd_t cmd;
		kind = $urandom % 10;
		if (kind == 0)
			cmd = OP_G90;
		else if (kind == 1)
			cmd = OP_G91;
		else if (kind < 6)
			cmd = OP_G00;
		else
			cmd = OP_G01;
		if ($urandom % 8 == 0) begin
			a1 = model_abs ? model_x : 0; // stays in place.
			a2 = model_abs ? model_y : 0;
		end else begin
			a1 = random_arg();
			a2 = random_arg();
		end
		send_op(cmd, a1, a2);
	endtask

	always @(posedge out_x) begin
		cycles++;
		if (cycles == LIMIT)
			abort_run("timeout: step pulses stopped arriving before all moves finished");
	end

	// outputs are stable at the falling edge.
	always @(negedge out_x) begin
		logic rise_x;
		logic rise_y;
		rise_x = pulse_x & ~prev_x;
		rise_y = pulse_y & ~prev_y;
		prev_x = pulse_x;
		prev_y = pulse_y;
		if (!rst && (rise_x || rise_y)) begin
			if (exp_dx.size() == 0) begin
				abort_run("a step pulse arrived with no move left to make");
			end else begin
				if (rise_x) begin
					check("dir_x", exp_dx[0] > 0, dir_x);
					cnt_x++;
					acc_x += dir_x ? 1 : -1;
					if (cnt_x > magnitude(exp_dx[0]))
						check("pulse_x count", magnitude(exp_dx[0]), cnt_x);
				end
				if (rise_y) begin
					check("dir_y", exp_dy[0] > 0, dir_y);
					cnt_y++;
					acc_y += dir_y ? 1 : -1;
					if (cnt_y > magnitude(exp_dy[0]))
						check("pulse_y count", magnitude(exp_dy[0]), cnt_y);
				end
				check("pen_down", exp_pen[0], pen_down);
				if (cnt_x == magnitude(exp_dx[0]) && cnt_y == magnitude(exp_dy[0])) begin
					void'(exp_dx.pop_front());
					void'(exp_dy.pop_front());
					void'(exp_pen.pop_front());
					cnt_x = 0;
					cnt_y = 0;
				end
			end
		end
	end

	initial begin
		int gap;
		out_x = 1'b0;
		rst = 1'b1;
		op_valid = 1'b0;
		op_cmd = OP_G00;
		op_arg_1 = '0;
		op_arg_2 = '0;
		void'($urandom(32'h61b39ea7));
		repeat (16) @(posedge out_x);
		#2;
		rst = 1'b0;
		repeat (20) begin
			@(negedge out_x);
			check("idle op_ready", 1, op_ready);
			check("idle pulse_x", 0, pulse_x);
			check("idle pulse_y", 0, pulse_y);
			check("idle pen_down", 0, pen_down);
		end
		@(posedge out_x);
		#2;
		for (int i = 0; i < NUM_OPS; i++) begin
			random_op();
			if ($urandom % 4 == 0) begin
				gap = 1 + $urandom % MAX_GAP;
				repeat (gap) @(posedge out_x);
				#2;
			end
		end
		while (exp_dx.size() != 0)
			@(posedge out_x);
		repeat (4 * EVENT_CYCLES + 20) @(posedge out_x); // watch for stray pulses.
		check("final x position", model_x, acc_x);
		check("final y position", model_y, acc_y);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+design
design/plotter_pkg.sv
design/gcode_decoder.sv
design/line_interpolator.sv
design/step_pulse_gen.sv
design/plotter_top.sv
tests/plotter_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = plotter_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
PASS_MSG = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
